//--- include/battle_config.svh
`ifndef BATTLE_CONFIG_SVH
`define BATTLE_CONFIG_SVH

// lane and army sizing
`define SLOT_COUNT 8

// clocks per game tick
`define TICK_PERIOD 64

// ticks of cooldown between spawns
`define SPAWN_COST 100

// enemy tower
`define TOWER_POS 300
`define TOWER_HEALTH 1000
`define TOWER_ATTACK 4

`endif

//--- logic/battlePkg.sv
`default_nettype none

`include "battle_config.svh"

package battlePkg;

	typedef logic [8:0] posT;
	typedef logic [11:0] healthT;
	typedef logic [`SLOT_COUNT-1:0] slotMaskT;

	// code 3 is never spawned
	typedef enum logic [1:0]
	{
		scout = 2'd0,
		soldier = 2'd1,
		archer = 2'd2
	} unitTypeT;

	typedef struct packed
	{
		posT speed;
		healthT health;
		healthT attack;
		posT range;
	} statsT;

	function automatic statsT unitStats(input unitTypeT kind);
		statsT stats;
		case (kind)
			scout: stats = '{speed: 9'd3, health: 12'd20, attack: 12'd1, range: 9'd0};
			soldier: stats = '{speed: 9'd2, health: 12'd40, attack: 12'd2, range: 9'd10};
			archer: stats = '{speed: 9'd1, health: 12'd15, attack: 12'd3, range: 9'd40};
			default: stats = '0;
		endcase
		return stats;
	endfunction

endpackage

`default_nettype wire

//--- logic/battleControl.sv
`timescale 1ns/1ps
`default_nettype none

`include "battle_config.svh"

module battleControl
(
	input logic ClkPort,
	input logic Reset,
	input logic pausePress,
	input logic towerDown,
	output logic tick,
	output logic running,
	output logic paused
);

	localparam int divWidth = $clog2(`TICK_PERIOD);
	localparam logic [divWidth-1:0] divLast = divWidth'(`TICK_PERIOD - 1);

	logic [divWidth-1:0] divCount;
	logic wrap;

	assign wrap = (divCount == divLast);

	// the divider keeps counting through a pause
	always_ff @(posedge ClkPort or posedge Reset)
	begin
		if (Reset)
			divCount <= '0;
		else if (wrap)
			divCount <= '0;
		else
			divCount <= divCount + 1'b1;
	end

	always_ff @(posedge ClkPort or posedge Reset)
	begin
		if (Reset)
			paused <= 1'b0;
		else if (pausePress)
			paused <= ~paused;
	end

	assign running = !paused && !towerDown;
	assign tick = wrap && running;

	// game over is final and keeps the tick silent
	assert property (@(posedge ClkPort) disable iff (Reset)
		towerDown |=> (towerDown && !tick));

endmodule

`default_nettype wire

//--- logic/spawnAllocator.sv
`timescale 1ns/1ps
`default_nettype none

`include "battle_config.svh"

module spawnAllocator
(
	input logic ClkPort,
	input logic Reset,
	input logic tick,
	input logic running,
	input logic spawnPress,
	input battlePkg::slotMaskT aliveMask,
	output battlePkg::slotMaskT spawnGrant,
	output logic ready
);

	import battlePkg::*;

	localparam int coolWidth = $clog2(`SPAWN_COST + 1);
	localparam logic [coolWidth-1:0] coolFull = coolWidth'(`SPAWN_COST);

	logic [coolWidth-1:0] coolCount;
	slotMaskT freeMask;
	slotMaskT lowestFree;
	logic accept;

	assign ready = (coolCount == coolFull);

	// lowest set bit of the free mask
	assign freeMask = ~aliveMask;
	assign lowestFree = freeMask & (~freeMask + slotMaskT'(1));

	assign accept = spawnPress && ready && running && (freeMask != '0);
	assign spawnGrant = accept ? lowestFree : '0;

	always_ff @(posedge ClkPort or posedge Reset)
	begin
		if (Reset)
			coolCount <= '0;
		else if (accept)
			coolCount <= '0;
		else if (tick && !ready)
			coolCount <= coolCount + 1'b1;
	end

	// the granted slot must show up alive after the load edge
	assert property (@(posedge ClkPort) disable iff (Reset)
		$onehot0(spawnGrant) && ((spawnGrant & aliveMask) == '0));
	assert property (@(posedge ClkPort) disable iff (Reset)
		(spawnGrant != '0) |=> ((aliveMask & $past(spawnGrant)) == $past(spawnGrant)));

endmodule

`default_nettype wire

//--- logic/unitSlot.sv
`timescale 1ns/1ps
`default_nettype none

`include "battle_config.svh"

module unitSlot
(
	input logic ClkPort,
	input logic Reset,
	input logic tick,
	input logic grant,
	input battlePkg::unitTypeT typeSelect,
	input logic hit,
	output logic alive,
	output battlePkg::unitTypeT unitType,
	output battlePkg::posT position,
	output logic engaged
);

	import battlePkg::*;

	localparam posT towerPos = posT'(`TOWER_POS);
	localparam healthT towerAttack = healthT'(`TOWER_ATTACK);

	statsT stats;
	statsT loadStats;
	healthT health;
	posT fireLine;
	logic [9:0] stepped;
	logic dies;

	assign stats = unitStats(unitType);
	assign loadStats = unitStats(typeSelect);

	// firing line sits range short of the tower
	assign fireLine = towerPos - stats.range;
	assign stepped = {1'b0, position} + {1'b0, stats.speed};
	assign engaged = alive && (position >= fireLine);

	assign dies = tick && hit && (health <= towerAttack);

	always_ff @(posedge ClkPort or posedge Reset)
	begin
		if (Reset)
			alive <= 1'b0;
		else if (grant)
			alive <= 1'b1;
		else if (alive && dies)
			alive <= 1'b0;
	end

	always_ff @(posedge ClkPort)
	begin
		if (grant)
		begin
			unitType <= typeSelect;
			position <= '0;
			health <= loadStats.health;
		end
		else if (tick && alive)
		begin
			if (hit)
			begin
				if (dies)
					health <= '0;
				else
					health <= health - towerAttack;
			end
			else if (!engaged)
			begin
				// march, stopping on the firing line
				if (stepped >= {1'b0, fireLine})
					position <= fireLine;
				else
					position <= stepped[8:0];
			end
		end
	end

	// a unit never walks past its own firing line
	assert property (@(posedge ClkPort) disable iff (Reset)
		alive |-> (position <= fireLine) && (position <= towerPos));

endmodule

`default_nettype wire

//--- logic/siegeResolver.sv
`timescale 1ns/1ps
`default_nettype none

`include "battle_config.svh"

module siegeResolver
(
	input logic ClkPort,
	input logic Reset,
	input logic tick,
	input battlePkg::slotMaskT aliveMask,
	input battlePkg::slotMaskT engagedMask,
	input battlePkg::posT positions [`SLOT_COUNT],
	input battlePkg::unitTypeT unitTypes [`SLOT_COUNT],
	output battlePkg::slotMaskT hitMask,
	output battlePkg::posT frontPos,
	output battlePkg::healthT towerHealth,
	output logic towerDown
);

	import battlePkg::*;

	localparam healthT towerStart = healthT'(`TOWER_HEALTH);

	healthT attackSum;
	slotMaskT target;
	posT targetPos;
	logic found;

	always_comb
	begin
		statsT unitStat;
		attackSum = '0;
		target = '0;
		targetPos = '0;
		found = 1'b0;
		frontPos = '0;
		for (int i = 0; i < `SLOT_COUNT; i++)
		begin
			unitStat = unitStats(unitTypes[i]);
			if (aliveMask[i] && (positions[i] > frontPos))
				frontPos = positions[i];
			if (aliveMask[i] && engagedMask[i])
			begin
				attackSum = attackSum + unitStat.attack;
				// strict compare keeps the lowest index on a tie
				if (!found || (positions[i] > targetPos))
				begin
					target = '0;
					target[i] = 1'b1;
					targetPos = positions[i];
					found = 1'b1;
				end
			end
		end
	end

	assign hitMask = tick ? target : '0;

	always_ff @(posedge ClkPort or posedge Reset)
	begin
		if (Reset)
			towerHealth <= towerStart;
		else if (tick)
		begin
			if (attackSum >= towerHealth)
				towerHealth <= '0;
			else
				towerHealth <= towerHealth - attackSum;
		end
	end

	assign towerDown = (towerHealth == '0);

	// the tower strikes at most once per tick
	assert property (@(posedge ClkPort) disable iff (Reset)
		$onehot0(hitMask) && ((hitMask == '0) || tick));

endmodule

`default_nettype wire

//--- logic/battleCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "battle_config.svh"

module battleCore
(
	input logic ClkPort,
	input logic Reset,
	input logic pausePress,
	input logic spawnPress,
	input battlePkg::unitTypeT typeSelect,
	output logic tick,
	output logic paused,
	output logic ready,
	output battlePkg::slotMaskT aliveMask,
	output battlePkg::posT frontPos,
	output battlePkg::healthT towerHealth,
	output logic towerDown
);

	import battlePkg::*;

	logic running;
	slotMaskT spawnGrant;
	slotMaskT engagedMask;
	slotMaskT hitMask;
	posT positions [`SLOT_COUNT];
	unitTypeT unitTypes [`SLOT_COUNT];

	battleControl control
	(
		.ClkPort(ClkPort),
		.Reset(Reset),
		.pausePress(pausePress),
		.towerDown(towerDown),
		.tick(tick),
		.running(running),
		.paused(paused)
	);

	spawnAllocator allocator
	(
		.ClkPort(ClkPort),
		.Reset(Reset),
		.tick(tick),
		.running(running),
		.spawnPress(spawnPress),
		.aliveMask(aliveMask),
		.spawnGrant(spawnGrant),
		.ready(ready)
	);

	// one slot per unit, all fed the same tick and type select
	for (genvar i = 0; i < `SLOT_COUNT; i++)
	begin : slotGen
		unitSlot unit
		(
			.ClkPort(ClkPort),
			.Reset(Reset),
			.tick(tick),
			.grant(spawnGrant[i]),
			.typeSelect(typeSelect),
			.hit(hitMask[i]),
			.alive(aliveMask[i]),
			.unitType(unitTypes[i]),
			.position(positions[i]),
			.engaged(engagedMask[i])
		);
	end

	siegeResolver resolver
	(
		.ClkPort(ClkPort),
		.Reset(Reset),
		.tick(tick),
		.aliveMask(aliveMask),
		.engagedMask(engagedMask),
		.positions(positions),
		.unitTypes(unitTypes),
		.hitMask(hitMask),
		.frontPos(frontPos),
		.towerHealth(towerHealth),
		.towerDown(towerDown)
	);

endmodule

`default_nettype wire

//--- tests/battleRefModel.sv
`default_nettype none

`include "battle_config.svh"

package battleRefModel;

	typedef struct
	{
		bit alive [`SLOT_COUNT];
		int kind [`SLOT_COUNT];
		int pos [`SLOT_COUNT];
		int health [`SLOT_COUNT];
		int tower;
	} modelT;

	// scout, soldier, archer
	function automatic int speedOf(input int kind);
		return (kind == 0) ? 3 : (kind == 1) ? 2 : 1;
	endfunction

	function automatic int healthOf(input int kind);
		return (kind == 0) ? 20 : (kind == 1) ? 40 : 15;
	endfunction

	function automatic int attackOf(input int kind);
		return (kind == 0) ? 1 : (kind == 1) ? 2 : 3;
	endfunction

	function automatic int rangeOf(input int kind);
		return (kind == 0) ? 0 : (kind == 1) ? 10 : 40;
	endfunction

	function automatic modelT resetModel();
		modelT m;
		for (int i = 0; i < `SLOT_COUNT; i++)
		begin
			m.alive[i] = 0;
			m.kind[i] = 0;
			m.pos[i] = 0;
			m.health[i] = 0;
		end
		m.tower = `TOWER_HEALTH;
		return m;
	endfunction

	// -1 when every slot is taken
	function automatic int firstFree(input modelT m);
		for (int i = 0; i < `SLOT_COUNT; i++)
			if (!m.alive[i])
				return i;
		return -1;
	endfunction

	function automatic int aliveMaskOf(input modelT m);
		int mask;
		mask = 0;
		for (int i = 0; i < `SLOT_COUNT; i++)
			if (m.alive[i])
				mask = mask | (1 << i);
		return mask;
	endfunction

	function automatic int frontOf(input modelT m);
		int front;
		front = 0;
		for (int i = 0; i < `SLOT_COUNT; i++)
			if (m.alive[i] && m.pos[i] > front)
				front = m.pos[i];
		return front;
	endfunction

	// one game tick: tower damage, tower strike, march
	function automatic modelT stepTick(input modelT m);
		modelT n;
		bit engaged [`SLOT_COUNT];
		int sum;
		int target;
		int line;
		n = m;
		sum = 0;
		target = -1;
		for (int i = 0; i < `SLOT_COUNT; i++)
		begin
			engaged[i] = m.alive[i] && (m.pos[i] >= `TOWER_POS - rangeOf(m.kind[i]));
			if (engaged[i])
			begin
				sum = sum + attackOf(m.kind[i]);
				if (target < 0 || m.pos[i] > m.pos[target])
					target = i;
			end
		end
		for (int i = 0; i < `SLOT_COUNT; i++)
		begin
			line = `TOWER_POS - rangeOf(m.kind[i]);
			if (!m.alive[i])
				continue;
			if (i == target)
			begin
				if (m.health[i] <= `TOWER_ATTACK)
				begin
					n.health[i] = 0;
					n.alive[i] = 0;
				end
				else
					n.health[i] = m.health[i] - `TOWER_ATTACK;
			end
			else if (!engaged[i])
				n.pos[i] = (m.pos[i] + speedOf(m.kind[i]) > line) ?
					line : m.pos[i] + speedOf(m.kind[i]);
		end
		n.tower = (sum >= m.tower) ? 0 : m.tower - sum;
		return n;
	endfunction

endpackage

`default_nettype wire

//--- tests/battleCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "battle_config.svh"

module battleCoreTb;

	import battlePkg::*;
	import battleRefModel::*;

	logic ClkPort;
	logic Reset;
	logic pausePress;
	logic spawnPress;
	unitTypeT typeSelect;
	logic tick;
	logic paused;
	logic ready;
	slotMaskT aliveMask;
	posT frontPos;
	healthT towerHealth;
	logic towerDown;

	modelT model;
	bit pending;
	int errorCount;
	int checkCount;
	int testCount;
	int testsFailed;

	battleCore dut
	(
		.ClkPort(ClkPort),
		.Reset(Reset),
		.pausePress(pausePress),
		.spawnPress(spawnPress),
		.typeSelect(typeSelect),
		.tick(tick),
		.paused(paused),
		.ready(ready),
		.aliveMask(aliveMask),
		.frontPos(frontPos),
		.towerHealth(towerHealth),
		.towerDown(towerDown)
	);

	initial
	begin
		ClkPort = 1'b0;
		forever #5 ClkPort = ~ClkPort;
	end

	task automatic checkVal(input string name, input int got, input int exp);
		checkCount++;
		assert (got == exp)
		else
		begin
			$display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, got);
			errorCount++;
		end
	endtask

	task automatic checkTrue(input bit cond, input string what);
		checkCount++;
		assert (cond)
		else
		begin
			$display("Error at %0t: %s", $time, what);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int startErrors);
		testCount++;
		if (errorCount == startErrors)
			$display("test %0d %s: ok", testCount, name);
		else
		begin
			testsFailed++;
			$display("test %0d %s: %0d errors", testCount, name, errorCount - startErrors);
		end
	endtask

	// returns on the falling edge inside the tick cycle
	task automatic waitTick(input int limit);
		bit seen;
		seen = 0;
		for (int n = 0; n < limit; n++)
		begin
			@(negedge ClkPort);
			if (tick)
			begin
				seen = 1;
				break;
			end
		end
		checkTrue(seen, "no tick arrived before the timeout");
	endtask

	// press on a quiet edge, away from the tick and the compare cycle
	task automatic spawnUnit();
		bit lastTick;
		bit found;
		int kind;
		int slot;
		lastTick = 1;
		found = 0;
		for (int n = 0; n < (`SPAWN_COST + 2) * `TICK_PERIOD; n++)
		begin
			@(negedge ClkPort);
			if (!tick && !lastTick && (ready || towerDown))
			begin
				found = 1;
				break;
			end
			lastTick = tick;
		end
		checkTrue(found, "spawn cooldown never finished");
		if (!found || towerDown)
			return;
		kind = $urandom % 3;
		slot = firstFree(model);
		spawnPress = 1'b1;
		typeSelect = unitTypeT'(kind);
		if (slot >= 0)
		begin
			model.alive[slot] = 1;
			model.kind[slot] = kind;
			model.pos[slot] = 0;
			model.health[slot] = healthOf(kind);
		end
		@(negedge ClkPort);
		spawnPress = 1'b0;
		checkVal("aliveMask", aliveMask, aliveMaskOf(model));
		checkVal("ready", ready, slot < 0);
	endtask

	// compares the cycle after each tick against the model
	always @(negedge ClkPort)
	begin
		if (Reset)
			pending = 0;
		else
		begin
			if (pending)
			begin
				model = stepTick(model);
				checkVal("aliveMask", aliveMask, aliveMaskOf(model));
				checkVal("frontPos", frontPos, frontOf(model));
				checkVal("towerHealth", towerHealth, model.tower);
				checkVal("towerDown", towerDown, model.tower == 0);
				pending = 0;
			end
			if (tick)
				pending = 1;
		end
	end

	initial
	begin
		repeat (4000000) @(posedge ClkPort);
		$display("simulation ran too long and was stopped");
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		int startErrors;
		int held;
		int mask;
		void'($urandom(32'h30f3));
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		testsFailed = 0;
		model = resetModel();
		Reset = 1'b1;
		pausePress = 1'b0;
		spawnPress = 1'b0;
		typeSelect = scout;
		repeat (4) @(posedge ClkPort);
		@(negedge ClkPort);
		Reset = 1'b0;

		startErrors = errorCount;
		checkVal("aliveMask", aliveMask, 0);
		checkVal("frontPos", frontPos, 0);
		checkVal("towerHealth", towerHealth, `TOWER_HEALTH);
		checkVal("ready", ready, 0);
		checkVal("paused", paused, 0);
		checkVal("towerDown", towerDown, 0);
		reportTest("reset state", startErrors);

		startErrors = errorCount;
		for (int n = 1; n <= `SPAWN_COST; n++)
		begin
			waitTick(2 * `TICK_PERIOD);
			@(negedge ClkPort);
			checkVal("ready", ready, n == `SPAWN_COST);
			if (n == `SPAWN_COST / 2)
			begin
				spawnPress = 1'b1;
				typeSelect = soldier;
				@(negedge ClkPort);
				spawnPress = 1'b0;
				checkVal("aliveMask", aliveMask, 0);
			end
		end
		reportTest("cooldown", startErrors);

		startErrors = errorCount;
		for (int k = 0; k < 3; k++)
			spawnUnit();
		reportTest("slot allocation", startErrors);

		startErrors = errorCount;
		waitTick(2 * `TICK_PERIOD);
		repeat (2) @(negedge ClkPort);
		pausePress = 1'b1;
		@(negedge ClkPort);
		pausePress = 1'b0;
		checkVal("paused", paused, 1);
		held = frontPos;
		for (int n = 0; n < 3 * `TICK_PERIOD; n++)
		begin
			@(negedge ClkPort);
			checkTrue(!tick, "tick appeared while paused");
			checkVal("frontPos", frontPos, held);
		end
		pausePress = 1'b1;
		@(negedge ClkPort);
		pausePress = 1'b0;
		checkVal("paused", paused, 0);
		waitTick(2 * `TICK_PERIOD);
		reportTest("pause", startErrors);

		startErrors = errorCount;
		for (int s = 0; s < 400 && !towerDown; s++)
			spawnUnit();
		checkTrue(towerDown, "tower was never destroyed");
		repeat (2) @(negedge ClkPort);
		checkVal("towerHealth", towerHealth, 0);
		mask = aliveMask;
		for (int n = 0; n < 2 * `TICK_PERIOD; n++)
		begin
			@(negedge ClkPort);
			checkTrue(!tick, "tick appeared after game over");
		end
		spawnPress = 1'b1;
		typeSelect = scout;
		@(negedge ClkPort);
		spawnPress = 1'b0;
		@(negedge ClkPort);
		checkVal("aliveMask", aliveMask, mask);
		reportTest("siege", startErrors);

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			testCount, testsFailed, checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
logic/battlePkg.sv
logic/battleControl.sv
logic/spawnAllocator.sv
logic/unitSlot.sv
logic/siegeResolver.sv
logic/battleCore.sv
tests/battleRefModel.sv
tests/battleCoreTb.sv

//--- Bender.yml
package:
  name: battle_core

sources:
  - include_dirs:
      - include
    files:
      - logic/battlePkg.sv
      - logic/battleControl.sv
      - logic/spawnAllocator.sv
      - logic/unitSlot.sv
      - logic/siegeResolver.sv
      - logic/battleCore.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/battleRefModel.sv
      - tests/battleCoreTb.sv
